// File: bench/tb_decode.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tb_decode
    import cpu_pkg::*;
();

    localparam int MAX_ROWS = 32;
    localparam int PRELOAD  = 8;

    logic       clk;
    logic       rst_n_i;
    Inst_addr_t pc_i;
    Inst_t      inst_i;
    Oper_t      ex_oper_i;
    Bit_t       ex_wreg_write_i;
    Reg_addr_t  ex_wreg_addr_i;
    Word_t      ex_wreg_data_i;
    Bit_t       mem_wreg_write_i;
    Reg_addr_t  mem_wreg_addr_i;
    Word_t      mem_wreg_data_i;
    Bit_t       wb_we_i;
    Reg_addr_t  wb_waddr_i;
    Word_t      wb_wdata_i;
    Bit_t       stall_o;
    Bit_t       branch_flag_o;
    Inst_addr_t branch_target_o;
    Oper_t      ex_oper_o;
    Word_t      ex_reg1_o;
    Word_t      ex_reg2_o;
    Bit_t       ex_wreg_write_o;
    Reg_addr_t  ex_wreg_addr_o;

    // stimulus columns.
    Inst_t      t_inst     [MAX_ROWS];
    Inst_addr_t t_pc       [MAX_ROWS];
    Oper_t      t_ex_oper  [MAX_ROWS];
    Bit_t       t_ex_we    [MAX_ROWS];
    Reg_addr_t  t_ex_addr  [MAX_ROWS];
    Word_t      t_ex_data  [MAX_ROWS];
    Bit_t       t_mem_we   [MAX_ROWS];
    Reg_addr_t  t_mem_addr [MAX_ROWS];
    Word_t      t_mem_data [MAX_ROWS];
    Bit_t       t_wb_we    [MAX_ROWS];
    Reg_addr_t  t_wb_addr  [MAX_ROWS];
    Word_t      t_wb_data  [MAX_ROWS];
    // expected columns.
    Oper_t      e_oper     [MAX_ROWS];
    Word_t      e_reg1     [MAX_ROWS];
    Word_t      e_reg2     [MAX_ROWS];
    Bit_t       e_we       [MAX_ROWS];
    Reg_addr_t  e_waddr    [MAX_ROWS];
    Bit_t       e_stall    [MAX_ROWS];
    Bit_t       e_flag     [MAX_ROWS];
    Inst_addr_t e_target   [MAX_ROWS];

    Word_t  model [16];
    int     n_rows;
    int     errors;
    int     checks;
    int     cycles;
    int     cycle_limit;
    integer seed;

    decode_top DUT (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .pc_i             (pc_i),
        .inst_i           (inst_i),
        .ex_oper_i        (ex_oper_i),
        .ex_wreg_write_i  (ex_wreg_write_i),
        .ex_wreg_addr_i   (ex_wreg_addr_i),
        .ex_wreg_data_i   (ex_wreg_data_i),
        .mem_wreg_write_i (mem_wreg_write_i),
        .mem_wreg_addr_i  (mem_wreg_addr_i),
        .mem_wreg_data_i  (mem_wreg_data_i),
        .wb_we_i          (wb_we_i),
        .wb_waddr_i       (wb_waddr_i),
        .wb_wdata_i       (wb_wdata_i),
        .stall_o          (stall_o),
        .branch_flag_o    (branch_flag_o),
        .branch_target_o  (branch_target_o),
        .ex_oper_o        (ex_oper_o),
        .ex_reg1_o        (ex_reg1_o),
        .ex_reg2_o        (ex_reg2_o),
        .ex_wreg_write_o  (ex_wreg_write_o),
        .ex_wreg_addr_o   (ex_wreg_addr_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: no result after %0d clock cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic Inst_t r_type(input logic [5:0] fn, input Reg_addr_t rs,
                                     input Reg_addr_t rt, input Reg_addr_t rd);
        return {`OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic Inst_t i_type(input logic [5:0] opc, input Reg_addr_t rs,
                                     input Reg_addr_t rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic Inst_t j_type(input logic [25:0] index);
        return {`OPC_J, index};
    endfunction

    task automatic stim(input Inst_t inst, input Inst_addr_t pc);
        t_inst[n_rows]     = inst;
        t_pc[n_rows]       = pc;
        t_ex_oper[n_rows]  = OP_NOP;
        t_ex_we[n_rows]    = 1'b0;
        t_ex_addr[n_rows]  = 5'd0;
        t_ex_data[n_rows]  = 32'h0;
        t_mem_we[n_rows]   = 1'b0;
        t_mem_addr[n_rows] = 5'd0;
        t_mem_data[n_rows] = 32'h0;
        t_wb_we[n_rows]    = 1'b0;
        t_wb_addr[n_rows]  = 5'd0;
        t_wb_data[n_rows]  = 32'h0;
    endtask

    task automatic fwd_ex(input Oper_t oper, input Reg_addr_t addr, input Word_t data);
        t_ex_oper[n_rows] = oper;
        t_ex_we[n_rows]   = 1'b1;
        t_ex_addr[n_rows] = addr;
        t_ex_data[n_rows] = data;
    endtask

    task automatic fwd_mem(input Reg_addr_t addr, input Word_t data);
        t_mem_we[n_rows]   = 1'b1;
        t_mem_addr[n_rows] = addr;
        t_mem_data[n_rows] = data;
    endtask

    task automatic write_back(input Reg_addr_t addr, input Word_t data);
        t_wb_we[n_rows]   = 1'b1;
        t_wb_addr[n_rows] = addr;
        t_wb_data[n_rows] = data;
    endtask

    task automatic expect_row(input Oper_t oper, input Word_t reg1, input Word_t reg2,
                              input Bit_t we, input Reg_addr_t waddr, input Bit_t stall,
                              input Bit_t flag, input Inst_addr_t target);
        e_oper[n_rows]   = oper;
        e_reg1[n_rows]   = reg1;
        e_reg2[n_rows]   = reg2;
        e_we[n_rows]     = we;
        e_waddr[n_rows]  = waddr;
        e_stall[n_rows]  = stall;
        e_flag[n_rows]   = flag;
        e_target[n_rows] = target;
        n_rows++;
    endtask

    task automatic check_oper(input string name, input Oper_t exp, input Oper_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %s, got %s",
                     $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_word(input string name, input Word_t exp, input Word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input Reg_addr_t exp, input Reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input Bit_t exp, input Bit_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input Inst_addr_t exp, input Inst_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic drive_row(input int i);
        inst_i           <= t_inst[i];
        pc_i             <= t_pc[i];
        ex_oper_i        <= t_ex_oper[i];
        ex_wreg_write_i  <= t_ex_we[i];
        ex_wreg_addr_i   <= t_ex_addr[i];
        ex_wreg_data_i   <= t_ex_data[i];
        mem_wreg_write_i <= t_mem_we[i];
        mem_wreg_addr_i  <= t_mem_addr[i];
        mem_wreg_data_i  <= t_mem_data[i];
        wb_we_i          <= t_wb_we[i];
        wb_waddr_i       <= t_wb_addr[i];
        wb_wdata_i       <= t_wb_data[i];
    endtask

    task automatic check_ex(input int i);
        check_oper("ex_oper_o", e_oper[i], ex_oper_o);
        check_word("ex_reg1_o", e_reg1[i], ex_reg1_o);
        check_word("ex_reg2_o", e_reg2[i], ex_reg2_o);
        check_bit("ex_wreg_write_o", e_we[i], ex_wreg_write_o);
        check_addr("ex_wreg_addr_o", e_waddr[i], ex_wreg_addr_o);
    endtask

    // bubble on the ex_ side, no stall and no branch.
    task automatic check_idle();
        check_oper("ex_oper_o", OP_NOP, ex_oper_o);
        check_word("ex_reg1_o", `ZERO_WORD, ex_reg1_o);
        check_word("ex_reg2_o", `ZERO_WORD, ex_reg2_o);
        check_bit("ex_wreg_write_o", 1'b0, ex_wreg_write_o);
        check_addr("ex_wreg_addr_o", `REG_ZERO, ex_wreg_addr_o);
        check_bit("stall_o", 1'b0, stall_o);
        check_bit("branch_flag_o", 1'b0, branch_flag_o);
    endtask

    task automatic build_table();
        stim(r_type(`FN_ADDU, 1, 2, 10), 32'h100);
        expect_row(OP_ADDU, model[1], model[2], 1'b1, 5'd10, 1'b0, 1'b0, 32'h0);
        stim(r_type(`FN_SUBU, 3, 4, 11), 32'h104);
        expect_row(OP_SUBU, model[3], model[4], 1'b1, 5'd11, 1'b0, 1'b0, 32'h0);
        stim(r_type(`FN_SLT, 5, 6, 12), 32'h108);
        expect_row(OP_SLT, model[5], model[6], 1'b1, 5'd12, 1'b0, 1'b0, 32'h0);
        stim(i_type(`OPC_ADDIU, 7, 13, 16'hfff0), 32'h10c);
        expect_row(OP_ADDIU, model[7], 32'hffff_fff0, 1'b1, 5'd13, 1'b0, 1'b0, 32'h0);
        stim(i_type(`OPC_ORI, 8, 14, 16'h8001), 32'h110);
        expect_row(OP_ORI, model[8], 32'h0000_8001, 1'b1, 5'd14, 1'b0, 1'b0, 32'h0);
        stim(i_type(`OPC_LUI, 0, 15, 16'h8001), 32'h114);
        expect_row(OP_LUI, 32'h8001_0000, 32'h8001_0000, 1'b1, 5'd15, 1'b0, 1'b0, 32'h0);
        // forwarding priority.
        stim(r_type(`FN_AND, 1, 2, 16), 32'h118);
        fwd_ex(OP_ADDU, 1, 32'heeee_0001);
        fwd_mem(2, 32'haaaa_0002);
        expect_row(OP_AND, 32'heeee_0001, 32'haaaa_0002, 1'b1, 5'd16, 1'b0, 1'b0, 32'h0);
        stim(r_type(`FN_OR, 1, 2, 17), 32'h11c);
        fwd_ex(OP_ADDU, 2, 32'heeee_0002);
        fwd_mem(2, 32'haaaa_0002);
        expect_row(OP_OR, model[1], 32'heeee_0002, 1'b1, 5'd17, 1'b0, 1'b0, 32'h0);
        stim(r_type(`FN_ADDU, 0, 3, 18), 32'h120);
        fwd_ex(OP_ADDU, 0, 32'h0000_dead); // r0 stays zero.
        fwd_mem(3, 32'h3333_0003);
        expect_row(OP_ADDU, 32'h0, 32'h3333_0003, 1'b1, 5'd18, 1'b0, 1'b0, 32'h0);
        stim(r_type(`FN_ADDU, 9, 0, 19), 32'h124);
        write_back(9, 32'h1234_5678);
        fwd_mem(0, 32'h0000_ffff);
        expect_row(OP_ADDU, 32'h1234_5678, 32'h0, 1'b1, 5'd19, 1'b0, 1'b0, 32'h0);
        // stores.
        stim(i_type(`OPC_SW, 5, 3, 16'hfffc), 32'h128);
        expect_row(OP_SW, model[5] + 32'hffff_fffc, model[3], 1'b0, 5'd0, 1'b0, 1'b0, 32'h0);
        stim(i_type(`OPC_SW, 6, 4, 16'h0008), 32'h12c);
        fwd_ex(OP_ADDIU, 6, 32'h0000_1000);
        expect_row(OP_SW, 32'h0000_1008, model[4], 1'b0, 5'd0, 1'b0, 1'b0, 32'h0);
        // load-use.
        stim(r_type(`FN_ADDU, 1, 2, 20), 32'h130);
        fwd_ex(OP_LW, 2, 32'h0000_5555);
        expect_row(OP_NOP, 32'h0, 32'h0, 1'b0, 5'd0, 1'b1, 1'b0, 32'h0);
        stim(r_type(`FN_ADDU, 1, 2, 20), 32'h130);
        fwd_mem(2, 32'h0000_5555); // held by fetch, load now in memory.
        expect_row(OP_ADDU, model[1], 32'h0000_5555, 1'b1, 5'd20, 1'b0, 1'b0, 32'h0);
        stim(r_type(`FN_ADDU, 1, 2, 21), 32'h134);
        fwd_ex(OP_LW, 3, 32'h0000_5555);
        expect_row(OP_ADDU, model[1], model[2], 1'b1, 5'd21, 1'b0, 1'b0, 32'h0);
        stim(i_type(`OPC_ORI, 1, 2, 16'h0005), 32'h138);
        fwd_ex(OP_LW, 2, 32'h0000_5555); // rt is a target, not a source.
        expect_row(OP_ORI, model[1], 32'h0000_0005, 1'b1, 5'd2, 1'b0, 1'b0, 32'h0);
        // branches.
        stim(i_type(`OPC_BEQ, 1, 1, 16'h0003), 32'h200);
        expect_row(OP_BEQ, model[1], model[1], 1'b0, 5'd0, 1'b0, 1'b1, 32'h210);
        stim(i_type(`OPC_BEQ, 1, 2, 16'h0001), 32'h600);
        fwd_ex(OP_ORI, 2, ~model[1]);
        expect_row(OP_BEQ, model[1], ~model[1], 1'b0, 5'd0, 1'b0, 1'b0, 32'h608);
        stim(i_type(`OPC_BEQ, 3, 4, 16'hfffc), 32'h300);
        fwd_ex(OP_ADDU, 4, model[3]);
        expect_row(OP_BEQ, model[3], model[3], 1'b0, 5'd0, 1'b0, 1'b1, 32'h2f4);
        stim(i_type(`OPC_BNE, 5, 6, 16'h0010), 32'h400);
        fwd_mem(6, model[5]);
        expect_row(OP_BNE, model[5], model[5], 1'b0, 5'd0, 1'b0, 1'b0, 32'h444);
        stim(i_type(`OPC_BNE, 7, 8, 16'hffff), 32'h500);
        fwd_mem(8, ~model[7]);
        expect_row(OP_BNE, model[7], ~model[7], 1'b0, 5'd0, 1'b0, 1'b1, 32'h500);
        stim(j_type(26'h000_0040), 32'h1000_0ffc);
        expect_row(OP_J, 32'h40, 32'h40, 1'b0, 5'd0, 1'b0, 1'b1, 32'h1000_0100);
        stim(32'h0, 32'h1000_1000);
        expect_row(OP_NOP, 32'h0, 32'h0, 1'b0, 5'd0, 1'b0, 1'b0, 32'h0);
    endtask

    initial begin
        clk              = 1'b0;
        rst_n_i          = 1'b0;
        pc_i             = 32'h0;
        inst_i           = i_type(`OPC_BEQ, 0, 0, 16'h0001); // taken if not gated.
        ex_oper_i        = OP_LW;
        ex_wreg_write_i  = 1'b1;
        ex_wreg_addr_i   = 5'd0;
        ex_wreg_data_i   = 32'h0;
        mem_wreg_write_i = 1'b0;
        mem_wreg_addr_i  = 5'd0;
        mem_wreg_data_i  = 32'h0;
        wb_we_i          = 1'b0;
        wb_waddr_i       = 5'd0;
        wb_wdata_i       = 32'h0;
        errors           = 0;
        checks           = 0;
        cycles           = 0;
        n_rows           = 0;
        seed             = 32'h5b8;

        for (int k = 0; k < 16; k++) begin
            model[k] = 32'h0;
        end
        for (int k = 1; k <= PRELOAD; k++) begin
            model[k] = $random(seed);
        end
        build_table();
        cycle_limit = (n_rows + PRELOAD + 20) * 2;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_idle();
        @(posedge clk);
        rst_n_i         <= 1'b1;
        inst_i          <= 32'h0;
        ex_oper_i       <= OP_NOP;
        ex_wreg_write_i <= 1'b0;
        @(negedge clk);
        check_idle();

        for (int k = 1; k <= PRELOAD; k++) begin
            @(posedge clk);
            wb_we_i    <= 1'b1;
            wb_waddr_i <= k[4:0];
            wb_wdata_i <= model[k];
        end

        // row i is decoded now, row i-1 sits in id_ex.
        for (int i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            if (i < n_rows) begin
                drive_row(i);
            end else begin
                drive_row(n_rows - 1);
            end
            @(negedge clk);
            if (i < n_rows) begin
                check_bit("stall_o", e_stall[i], stall_o);
                check_bit("branch_flag_o", e_flag[i], branch_flag_o);
                check_pc("branch_target_o", e_target[i], branch_target_o);
            end
            if (i > 0) begin
                check_ex(i - 1);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_W          32
`define REG_ADDR_W      5
`define REG_NUM         32
`define OPCODE_W        6
`define IMM_W           16

`define ZERO_WORD       32'h0000_0000
`define REG_ZERO        5'd0
`define PC_RESET_ADDR   32'h0000_0000
`define PC_STEP         32'd4
`define ENABLE          1'b1
`define DISABLE         1'b0

// primary opcodes.
`define OPC_SPECIAL     6'h00
`define OPC_J           6'h02
`define OPC_BEQ         6'h04
`define OPC_BNE         6'h05
`define OPC_ADDIU       6'h09
`define OPC_ORI         6'h0d
`define OPC_LUI         6'h0f
`define OPC_LW          6'h23
`define OPC_SW          6'h2b

// funct field, special opcode only.
`define FN_ADDU         6'h21
`define FN_SUBU         6'h23
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_SLT          6'h2a

`define NEED_LOAD(op)   ((op) == OP_LW)
`define NEED_SAVE(op)   ((op) == OP_SW)

`endif

// File: common/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_SLT,
        OP_ADDIU,
        OP_ORI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_J
    } Oper_t;

    typedef logic [`WORD_W-1:0]     Word_t;
    typedef logic [`WORD_W-1:0]     Inst_t;
    typedef logic [`WORD_W-1:0]     Inst_addr_t;
    typedef logic [`REG_ADDR_W-1:0] Reg_addr_t;
    typedef logic                   Bit_t;

endpackage

// File: decode/branch.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module branch
    import cpu_pkg::*;
(
    input  logic       rst_n_i,
    input  Oper_t      oper_i,
    input  Inst_addr_t pc_i,
    input  Word_t      reg1_i,
    input  Word_t      reg2_i,
    input  Word_t      imm_i,
    output Bit_t       branch_flag_o,
    output Inst_addr_t branch_target_o
);

    Inst_addr_t pc_plus4;
    Inst_addr_t rel_target;
    Inst_addr_t jmp_target;
    Bit_t       equal;

    assign pc_plus4   = pc_i + `PC_STEP;
    assign rel_target = pc_plus4 + {imm_i[`WORD_W-3:0], 2'b00};
    assign jmp_target = {pc_plus4[31:28], imm_i[25:0], 2'b00};
    assign equal      = (reg1_i == reg2_i);

    always_comb begin
        branch_flag_o   = `DISABLE;
        branch_target_o = `PC_RESET_ADDR;
        if (rst_n_i == 1'b0) begin
            branch_flag_o   = `DISABLE;
            branch_target_o = `PC_RESET_ADDR;
        end else begin
            case (oper_i)
                OP_BEQ: begin
                    branch_flag_o   = equal;
                    branch_target_o = rel_target;
                end
                OP_BNE: begin
                    branch_flag_o   = !equal;
                    branch_target_o = rel_target;
                end
                OP_J: begin
                    branch_flag_o   = `ENABLE; // always taken.
                    branch_target_o = jmp_target;
                end
                default: begin
                    branch_flag_o   = `DISABLE;
                    branch_target_o = `PC_RESET_ADDR;
                end
            endcase
        end
    end

endmodule

// File: decode/id.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module id
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  Inst_addr_t pc_i,
    input  Inst_t      inst_i,
    input  Word_t      reg1_data_i,
    input  Word_t      reg2_data_i,

    output Bit_t       reg1_read_o,
    output Bit_t       reg2_read_o,
    output Reg_addr_t  reg1_addr_o,
    output Reg_addr_t  reg2_addr_o,

    output Oper_t      oper_o,
    output Word_t      reg1_o,
    output Word_t      reg2_o,
    output Bit_t       wreg_write_o,
    output Reg_addr_t  wreg_addr_o,

    input  Oper_t      ex_oper_i,
    input  Bit_t       ex_wreg_write_i,
    input  Reg_addr_t  ex_wreg_addr_i,
    input  Word_t      ex_wreg_data_i,
    input  Bit_t       mem_wreg_write_i,
    input  Reg_addr_t  mem_wreg_addr_i,
    input  Word_t      mem_wreg_data_i,

    output Bit_t       branch_flag_o,
    output Inst_addr_t branch_target_o,
    output Bit_t       stallreq_o
);

    Oper_t     oper;
    Bit_t      reg1_read;
    Bit_t      reg2_read;
    Reg_addr_t reg1_addr;
    Reg_addr_t reg2_addr;
    Bit_t      wreg_write;
    Reg_addr_t wreg_addr;
    Word_t     imm;
    Word_t     reg1_fwd;

    // newest value wins: execute, then memory, then the register file.
    function automatic Word_t pick_operand(
        input Bit_t      re,
        input Reg_addr_t addr,
        input Word_t     rf_data,
        input Word_t     imm_val,
        input Bit_t      ex_we,
        input Reg_addr_t ex_addr,
        input Word_t     ex_data,
        input Bit_t      mem_we,
        input Reg_addr_t mem_addr,
        input Word_t     mem_data
    );
        Word_t val;
        if (re && ex_we && ex_addr == addr) begin
            val = (ex_addr != `REG_ZERO) ? ex_data : `ZERO_WORD;
        end else if (re && mem_we && mem_addr == addr) begin
            val = (mem_addr != `REG_ZERO) ? mem_data : `ZERO_WORD;
        end else if (re) begin
            val = rf_data;
        end else begin
            val = imm_val;
        end
        return val;
    endfunction

    id_type u_id_type (
        .inst_i       (inst_i),
        .oper_o       (oper),
        .reg1_read_o  (reg1_read),
        .reg2_read_o  (reg2_read),
        .reg1_addr_o  (reg1_addr),
        .reg2_addr_o  (reg2_addr),
        .wreg_write_o (wreg_write),
        .wreg_addr_o  (wreg_addr),
        .imm_o        (imm)
    );

    branch u_branch (
        .rst_n_i         (rst_n_i),
        .oper_i          (oper_o),
        .pc_i            (pc_i),
        .reg1_i          (reg1_fwd), // branches compare the raw operand.
        .reg2_i          (reg2_o),
        .imm_i           (imm),
        .branch_flag_o   (branch_flag_o),
        .branch_target_o (branch_target_o)
    );

    always_comb begin
        if (rst_n_i == 1'b0) begin
            oper_o       = OP_NOP;
            reg1_read_o  = `DISABLE;
            reg2_read_o  = `DISABLE;
            reg1_addr_o  = `REG_ZERO;
            reg2_addr_o  = `REG_ZERO;
            wreg_write_o = `DISABLE;
            wreg_addr_o  = `REG_ZERO;
            reg1_fwd     = `ZERO_WORD;
            reg2_o       = `ZERO_WORD;
        end else begin
            oper_o       = oper;
            reg1_read_o  = reg1_read;
            reg2_read_o  = reg2_read;
            reg1_addr_o  = reg1_addr;
            reg2_addr_o  = reg2_addr;
            wreg_write_o = wreg_write;
            wreg_addr_o  = wreg_addr;
            reg1_fwd     = pick_operand(reg1_read, reg1_addr, reg1_data_i, imm,
                                        ex_wreg_write_i, ex_wreg_addr_i, ex_wreg_data_i,
                                        mem_wreg_write_i, mem_wreg_addr_i, mem_wreg_data_i);
            reg2_o       = pick_operand(reg2_read, reg2_addr, reg2_data_i, imm,
                                        ex_wreg_write_i, ex_wreg_addr_i, ex_wreg_data_i,
                                        mem_wreg_write_i, mem_wreg_addr_i, mem_wreg_data_i);
        end
    end

    // store address formed here.
    assign reg1_o = `NEED_SAVE(oper_o) ? (reg1_fwd + imm) : reg1_fwd;

    always_comb begin
        stallreq_o = `DISABLE;
        if (rst_n_i == 1'b1 && `NEED_LOAD(ex_oper_i)) begin
            stallreq_o = (reg1_read_o && ex_wreg_addr_i == reg1_addr_o) ||
                         (reg2_read_o && ex_wreg_addr_i == reg2_addr_o);
        end
    end

    a_stall_on_load: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stallreq_o |-> (`NEED_LOAD(ex_oper_i) && ex_wreg_write_i)
    );

endmodule

// File: decode/id_type.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module id_type
    import cpu_pkg::*;
(
    input  Inst_t     inst_i,
    output Oper_t     oper_o,
    output Bit_t      reg1_read_o,
    output Bit_t      reg2_read_o,
    output Reg_addr_t reg1_addr_o,
    output Reg_addr_t reg2_addr_o,
    output Bit_t      wreg_write_o,
    output Reg_addr_t wreg_addr_o,
    output Word_t     imm_o
);

    logic [`OPCODE_W-1:0] opcode;
    logic [`OPCODE_W-1:0] funct;
    logic [`IMM_W-1:0]    imm16;
    Reg_addr_t            rs;
    Reg_addr_t            rt;
    Reg_addr_t            rd;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;

    always_comb begin
        oper_o       = OP_NOP;
        reg1_read_o  = `DISABLE;
        reg2_read_o  = `DISABLE;
        wreg_write_o = `DISABLE;
        wreg_addr_o  = `REG_ZERO;
        case (opcode)
            `OPC_SPECIAL: begin
                case (funct)
                    `FN_ADDU: oper_o = OP_ADDU;
                    `FN_SUBU: oper_o = OP_SUBU;
                    `FN_AND:  oper_o = OP_AND;
                    `FN_OR:   oper_o = OP_OR;
                    `FN_SLT:  oper_o = OP_SLT;
                    default:  oper_o = OP_NOP;
                endcase
                if (oper_o != OP_NOP) begin
                    reg1_read_o  = `ENABLE;
                    reg2_read_o  = `ENABLE;
                    wreg_write_o = `ENABLE;
                    wreg_addr_o  = rd; // r-type writes rd.
                end
            end
            `OPC_ADDIU, `OPC_ORI, `OPC_LW: begin
                oper_o       = (opcode == `OPC_ADDIU) ? OP_ADDIU :
                               (opcode == `OPC_ORI)   ? OP_ORI   : OP_LW;
                reg1_read_o  = `ENABLE;
                wreg_write_o = `ENABLE;
                wreg_addr_o  = rt;
            end
            `OPC_LUI: begin
                oper_o       = OP_LUI; // both operands take the immediate.
                wreg_write_o = `ENABLE;
                wreg_addr_o  = rt;
            end
            `OPC_SW: begin
                oper_o      = OP_SW;
                reg1_read_o = `ENABLE; // base.
                reg2_read_o = `ENABLE; // store data.
            end
            `OPC_BEQ, `OPC_BNE: begin
                oper_o      = (opcode == `OPC_BEQ) ? OP_BEQ : OP_BNE;
                reg1_read_o = `ENABLE;
                reg2_read_o = `ENABLE;
            end
            `OPC_J: begin
                oper_o = OP_J;
            end
            default: begin
                oper_o = OP_NOP;
            end
        endcase
    end

    // extension by opcode.
    always_comb begin
        case (oper_o)
            OP_ORI:  imm_o = {{(`WORD_W-`IMM_W){1'b0}}, imm16};
            OP_LUI:  imm_o = {imm16, {(`WORD_W-`IMM_W){1'b0}}};
            // jump index rides in the immediate for the target adder.
            OP_J:    imm_o = {6'b0, inst_i[25:0]};
            default: imm_o = {{(`WORD_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
        endcase
    end

endmodule

// File: rtl/decode_top.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module decode_top
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  Inst_addr_t pc_i,
    input  Inst_t      inst_i,

    input  Oper_t      ex_oper_i,
    input  Bit_t       ex_wreg_write_i,
    input  Reg_addr_t  ex_wreg_addr_i,
    input  Word_t      ex_wreg_data_i,
    input  Bit_t       mem_wreg_write_i,
    input  Reg_addr_t  mem_wreg_addr_i,
    input  Word_t      mem_wreg_data_i,

    input  Bit_t       wb_we_i,
    input  Reg_addr_t  wb_waddr_i,
    input  Word_t      wb_wdata_i,

    output Bit_t       stall_o,
    output Bit_t       branch_flag_o,
    output Inst_addr_t branch_target_o,

    output Oper_t      ex_oper_o,
    output Word_t      ex_reg1_o,
    output Word_t      ex_reg2_o,
    output Bit_t       ex_wreg_write_o,
    output Reg_addr_t  ex_wreg_addr_o
);

    Bit_t      rf_re1;
    Bit_t      rf_re2;
    Reg_addr_t rf_raddr1;
    Reg_addr_t rf_raddr2;
    Word_t     rf_rdata1;
    Word_t     rf_rdata2;
    Oper_t     id_oper;
    Word_t     id_reg1;
    Word_t     id_reg2;
    Bit_t      id_wreg_write;
    Reg_addr_t id_wreg_addr;

    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i),
        .re1_i    (rf_re1),
        .raddr1_i (rf_raddr1),
        .rdata1_o (rf_rdata1),
        .re2_i    (rf_re2),
        .raddr2_i (rf_raddr2),
        .rdata2_o (rf_rdata2)
    );

    id u_id (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .pc_i             (pc_i),
        .inst_i           (inst_i),
        .reg1_data_i      (rf_rdata1),
        .reg2_data_i      (rf_rdata2),
        .reg1_read_o      (rf_re1),
        .reg2_read_o      (rf_re2),
        .reg1_addr_o      (rf_raddr1),
        .reg2_addr_o      (rf_raddr2),
        .oper_o           (id_oper),
        .reg1_o           (id_reg1),
        .reg2_o           (id_reg2),
        .wreg_write_o     (id_wreg_write),
        .wreg_addr_o      (id_wreg_addr),
        .ex_oper_i        (ex_oper_i),
        .ex_wreg_write_i  (ex_wreg_write_i),
        .ex_wreg_addr_i   (ex_wreg_addr_i),
        .ex_wreg_data_i   (ex_wreg_data_i),
        .mem_wreg_write_i (mem_wreg_write_i),
        .mem_wreg_addr_i  (mem_wreg_addr_i),
        .mem_wreg_data_i  (mem_wreg_data_i),
        .branch_flag_o    (branch_flag_o),
        .branch_target_o  (branch_target_o),
        .stallreq_o       (stall_o)
    );

    id_ex u_id_ex (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_o),
        .id_oper_i       (id_oper),
        .id_reg1_i       (id_reg1),
        .id_reg2_i       (id_reg2),
        .id_wreg_write_i (id_wreg_write),
        .id_wreg_addr_i  (id_wreg_addr),
        .ex_oper_o       (ex_oper_o),
        .ex_reg1_o       (ex_reg1_o),
        .ex_reg2_o       (ex_reg2_o),
        .ex_wreg_write_o (ex_wreg_write_o),
        .ex_wreg_addr_o  (ex_wreg_addr_o)
    );

endmodule

// File: rtl/id_ex.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module id_ex
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  Bit_t      stall_i,

    input  Oper_t     id_oper_i,
    input  Word_t     id_reg1_i,
    input  Word_t     id_reg2_i,
    input  Bit_t      id_wreg_write_i,
    input  Reg_addr_t id_wreg_addr_i,

    output Oper_t     ex_oper_o,
    output Word_t     ex_reg1_o,
    output Word_t     ex_reg2_o,
    output Bit_t      ex_wreg_write_o,
    output Reg_addr_t ex_wreg_addr_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_oper_o       <= OP_NOP;
            ex_reg1_o       <= `ZERO_WORD;
            ex_reg2_o       <= `ZERO_WORD;
            ex_wreg_write_o <= `DISABLE;
            ex_wreg_addr_o  <= `REG_ZERO;
        end else if (stall_i) begin
            ex_oper_o       <= OP_NOP; // bubble while the load completes.
            ex_reg1_o       <= `ZERO_WORD;
            ex_reg2_o       <= `ZERO_WORD;
            ex_wreg_write_o <= `DISABLE;
            ex_wreg_addr_o  <= `REG_ZERO;
        end else begin
            ex_oper_o       <= id_oper_i;
            ex_reg1_o       <= id_reg1_i;
            ex_reg2_o       <= id_reg2_i;
            ex_wreg_write_o <= id_wreg_write_i;
            ex_wreg_addr_o  <= id_wreg_addr_i;
        end
    end

    a_bubble_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stall_i |=> (ex_oper_o == OP_NOP && ex_wreg_write_o == `DISABLE)
    );

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module regfile
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  Bit_t      we_i,
    input  Reg_addr_t waddr_i,
    input  Word_t     wdata_i,
    input  Bit_t      re1_i,
    input  Reg_addr_t raddr1_i,
    output Word_t     rdata1_o,
    input  Bit_t      re2_i,
    input  Reg_addr_t raddr2_i,
    output Word_t     rdata2_o
);

    Word_t regs [`REG_NUM];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= `ZERO_WORD;
            end
        end else if (we_i && waddr_i != `REG_ZERO) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so decode sees the write-back value this cycle.
    assign rdata1_o = !re1_i                                                ? `ZERO_WORD :
                      (we_i && waddr_i != `REG_ZERO && waddr_i == raddr1_i) ? wdata_i    :
                      regs[raddr1_i];
    assign rdata2_o = !re2_i                                                ? `ZERO_WORD :
                      (we_i && waddr_i != `REG_ZERO && waddr_i == raddr2_i) ? wdata_i    :
                      regs[raddr2_i];

    a_r0_port1: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (re1_i && raddr1_i == `REG_ZERO) |-> rdata1_o == `ZERO_WORD
    );
    a_r0_port2: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (re2_i && raddr2_i == `REG_ZERO) |-> rdata2_o == `ZERO_WORD
    );

endmodule

// File: tb.f
+incdir+common
common/cpu_pkg.sv
rtl/regfile.sv
decode/id_type.sv
decode/branch.sv
decode/id.sv
rtl/id_ex.sv
rtl/decode_top.sv
bench/tb_decode.sv
